// File: ldu_pkg.sv
// --------------------------------------
// ldu_pkg
// widths, vector types, records and the
// request FSM encoding shared by the load
// unit address stage
// --------------------------------------
package ldu_pkg;

	// --------------------------------------
	// sizes

	// register file banks on the forward bus
	localparam int PRF_BANK_COUNT = 4;
	localparam int LOG_PRF_BANK_COUNT = $clog2(PRF_BANK_COUNT);

	// load completion queue
	localparam int LDU_CQ_ENTRIES = 16;
	localparam int LOG_LDU_CQ_ENTRIES = $clog2(LDU_CQ_ENTRIES);

	// 4 KiB pages
	localparam int VPN_WIDTH = 20;
	localparam int PO_WIDTH = 12;

	// 32-byte lines interleaved over two banks
	localparam int DCACHE_BANK_BIT = 5;

	// access size in op[1:0]
	localparam logic [1:0] LDU_SIZE_BYTE = 2'b00;
	localparam logic [1:0] LDU_SIZE_HALF = 2'b01;
	localparam logic [1:0] LDU_SIZE_WORD = 2'b10;

	// --------------------------------------
	// vector types

	typedef logic [31:0] vaddr_t;
	typedef logic [31:0] word_t;
	// bit 2 set for unsigned loads
	typedef logic [3:0] ldu_op_t;
	typedef logic [11:0] imm12_t;
	typedef logic [LOG_PRF_BANK_COUNT-1:0] prf_bank_t;
	typedef logic [LOG_LDU_CQ_ENTRIES-1:0] cq_index_t;
	typedef logic [VPN_WIDTH-1:0] vpn_t;
	// page offset minus byte-in-word bits
	typedef logic [PO_WIDTH-3:0] po_word_t;
	typedef logic [3:0] byte_mask_t;

	// --------------------------------------
	// records

	// load from the issue queue
	typedef struct packed {
		logic valid;
		ldu_op_t op;
		imm12_t imm12;
		logic A_forward;
		logic A_is_zero;
		prf_bank_t A_bank;
		cq_index_t cq_index;
	} ldu_issue_t;

	// generated address on its way to the request stage
	typedef struct packed {
		logic valid;
		vaddr_t vaddr;
		ldu_op_t op;
		cq_index_t cq_index;
	} ldu_addr_t;

	// request to a data cache bank
	typedef struct packed {
		logic is_mq;
		logic misaligned;
		vpn_t vpn;
		po_word_t po_word;
		byte_mask_t byte_mask;
		cq_index_t cq_index;
	} ldu_req_t;

	typedef enum logic [1:0] {
		REQ_IDLE,
		REQ_FIRST,
		REQ_SECOND
	} req_state_t;

endpackage

// File: ldu_operand_stage.sv
// --------------------------------------
// ldu_operand_stage
// holds one issued load and gathers base
// operand A from zero, the forward bus or
// a register read response
// --------------------------------------
`timescale 1ns/1ps

module ldu_operand_stage (
	input logic CLK,
	input logic nRST,

	// issue queue side
	input ldu_pkg::ldu_issue_t issue,
	output logic issue_ready,

	// register file side
	input logic A_reg_read_resp_valid,
	input ldu_pkg::word_t A_reg_read_resp_data,
	input ldu_pkg::word_t [ldu_pkg::PRF_BANK_COUNT-1:0] forward_data_by_bank,

	// to address generation
	output logic operand_valid,
	output ldu_pkg::word_t operand_A,
	output ldu_pkg::ldu_op_t operand_op,
	output ldu_pkg::imm12_t operand_imm12,
	output ldu_pkg::cq_index_t operand_cq_index,
	input logic addr_ready
);

	// control
	logic held_valid;
	logic a_present;
	logic fwd_pending;

	// held payload
	ldu_pkg::ldu_op_t op_q;
	ldu_pkg::imm12_t imm12_q;
	ldu_pkg::prf_bank_t bank_q;
	ldu_pkg::cq_index_t cq_index_q;
	ldu_pkg::word_t a_q;

	logic issue_fire;
	logic operand_fire;
	logic a_capture;

	// operand is usable once present, on the forward cycle or on the response strobe
	assign operand_valid = held_valid & (a_present | fwd_pending | A_reg_read_resp_valid);
	assign operand_fire = operand_valid & addr_ready;

	// full and stuck means no new issue
	assign issue_ready = ~held_valid | operand_fire;
	assign issue_fire = issue.valid & issue_ready;

	// keep the operand when it shows up but cannot move on yet
	assign a_capture = operand_valid & ~a_present & ~addr_ready;

	always_comb begin
		if (a_present) begin
			operand_A = a_q;
		end else if (fwd_pending) begin
			operand_A = forward_data_by_bank[bank_q];
		end else begin
			operand_A = A_reg_read_resp_data;
		end
	end

	assign operand_op = op_q;
	assign operand_imm12 = imm12_q;
	assign operand_cq_index = cq_index_q;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			held_valid <= 1'b0;
			a_present <= 1'b0;
			fwd_pending <= 1'b0;
		end else if (issue_fire) begin
			held_valid <= 1'b1;
			a_present <= issue.A_is_zero;
			// forward bus is only good for one cycle
			fwd_pending <= issue.A_forward & ~issue.A_is_zero;
		end else if (operand_fire) begin
			held_valid <= 1'b0;
			a_present <= 1'b0;
			fwd_pending <= 1'b0;
		end else if (a_capture) begin
			a_present <= 1'b1;
			fwd_pending <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (issue_fire) begin
			op_q <= issue.op;
			imm12_q <= issue.imm12;
			bank_q <= issue.A_bank;
			cq_index_q <= issue.cq_index;
			a_q <= '0;
		end else if (a_capture) begin
			a_q <= operand_A;
		end
	end

	// a register response is only legal for a load still waiting on it
	a_resp_expected: assert property (@(posedge CLK) disable iff (!nRST)
		A_reg_read_resp_valid |-> (held_valid && !a_present && !fwd_pending));

endmodule

// File: ldu_addr_gen.sv
// --------------------------------------
// ldu_addr_gen
// virtual address = operand A plus the
// sign-extended immediate, registered
// --------------------------------------
`timescale 1ns/1ps

module ldu_addr_gen (
	input logic CLK,
	input logic nRST,

	// from the operand stage
	input logic operand_valid,
	input ldu_pkg::word_t operand_A,
	input ldu_pkg::ldu_op_t operand_op,
	input ldu_pkg::imm12_t operand_imm12,
	input ldu_pkg::cq_index_t operand_cq_index,
	output logic addr_ready,

	// to the request stage
	output ldu_pkg::ldu_addr_t addr,
	input logic accept
);

	logic valid_q;
	ldu_pkg::vaddr_t vaddr_q;
	ldu_pkg::ldu_op_t op_q;
	ldu_pkg::cq_index_t cq_index_q;

	ldu_pkg::vaddr_t imm_sext;
	ldu_pkg::vaddr_t vaddr_sum;

	// --------------------------------------
	// address add

	assign imm_sext = {{20{operand_imm12[11]}}, operand_imm12};
	assign vaddr_sum = operand_A + imm_sext;

	// register moves when empty or when its record leaves
	assign addr_ready = ~valid_q | accept;

	// --------------------------------------
	// pipeline register

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= 1'b0;
		end else if (addr_ready) begin
			valid_q <= operand_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (addr_ready && operand_valid) begin
			vaddr_q <= vaddr_sum;
			op_q <= operand_op;
			cq_index_q <= operand_cq_index;
		end
	end

	always_comb begin
		addr.valid = valid_q;
		addr.vaddr = vaddr_q;
		addr.op = op_q;
		addr.cq_index = cq_index_q;
	end

	// a record waiting on the request stage must not move
	addr_held_stable: assert property (@(posedge CLK) disable iff (!nRST)
		(addr.valid && !accept) |=> (addr.valid && $stable(addr)));

endmodule

// File: ldu_req_stage.sv
// --------------------------------------
// ldu_req_stage
// forms the byte mask, bank select and
// misaligned split and holds each request
// until its cache bank is early-ready
// --------------------------------------
`timescale 1ns/1ps

module ldu_req_stage (
	input logic CLK,
	input logic nRST,

	// from address generation
	input ldu_pkg::ldu_addr_t addr,
	output logic accept,

	// to the data cache
	output logic REQ_bank0_valid,
	output logic REQ_bank1_valid,
	output ldu_pkg::ldu_req_t req,
	input logic REQ_bank0_early_ready,
	input logic REQ_bank1_early_ready
);

	ldu_pkg::req_state_t state;
	ldu_pkg::req_state_t state_next;

	// current request and the pending second half
	ldu_pkg::ldu_req_t cur_req;
	logic cur_bank;
	ldu_pkg::ldu_req_t sec_req;
	logic sec_bank;

	// decode of the incoming address
	logic [3:0] size_mask;
	logic [7:0] mask_shifted;
	logic in_misaligned;
	ldu_pkg::vaddr_t next_vaddr;
	ldu_pkg::ldu_req_t in_first;
	ldu_pkg::ldu_req_t in_second;

	logic busy;
	logic done;
	logic load_new;

	// --------------------------------------
	// mask and split decode

	always_comb begin
		case (addr.op[1:0])
			ldu_pkg::LDU_SIZE_BYTE: size_mask = 4'b0001;
			ldu_pkg::LDU_SIZE_HALF: size_mask = 4'b0011;
			default: size_mask = 4'b1111;
		endcase
	end

	// bytes pushed past bit 3 belong to the next word
	assign mask_shifted = {4'b0000, size_mask} << addr.vaddr[1:0];
	assign in_misaligned = |mask_shifted[7:4];
	assign next_vaddr = {addr.vaddr[31:2] + 30'd1, 2'b00};

	always_comb begin
		in_first.is_mq = 1'b0;
		in_first.misaligned = in_misaligned;
		in_first.vpn = addr.vaddr[31:ldu_pkg::PO_WIDTH];
		in_first.po_word = addr.vaddr[ldu_pkg::PO_WIDTH-1:2];
		in_first.byte_mask = mask_shifted[3:0];
		in_first.cq_index = addr.cq_index;

		in_second.is_mq = 1'b1;
		in_second.misaligned = 1'b0;
		in_second.vpn = next_vaddr[31:ldu_pkg::PO_WIDTH];
		in_second.po_word = next_vaddr[ldu_pkg::PO_WIDTH-1:2];
		in_second.byte_mask = mask_shifted[7:4];
		in_second.cq_index = addr.cq_index;
	end

	// --------------------------------------
	// request FSM

	assign busy = (state != ldu_pkg::REQ_IDLE);
	assign REQ_bank0_valid = busy & ~cur_bank;
	assign REQ_bank1_valid = busy & cur_bank;
	assign req = cur_req;

	assign done = (REQ_bank0_valid & REQ_bank0_early_ready)
		| (REQ_bank1_valid & REQ_bank1_early_ready);

	// free unless a second half still has to go out
	assign accept = ~busy | (done & ~(state == ldu_pkg::REQ_FIRST && cur_req.misaligned));
	assign load_new = accept & addr.valid;

	always_comb begin
		state_next = state;
		case (state)
			ldu_pkg::REQ_IDLE: begin
				if (load_new) state_next = ldu_pkg::REQ_FIRST;
			end
			ldu_pkg::REQ_FIRST: begin
				if (done && cur_req.misaligned) state_next = ldu_pkg::REQ_SECOND;
				else if (done && !load_new) state_next = ldu_pkg::REQ_IDLE;
			end
			ldu_pkg::REQ_SECOND: begin
				if (done) begin
					state_next = load_new ? ldu_pkg::REQ_FIRST : ldu_pkg::REQ_IDLE;
				end
			end
			default: state_next = ldu_pkg::REQ_IDLE;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= ldu_pkg::REQ_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge CLK) begin
		if (load_new) begin
			cur_req <= in_first;
			cur_bank <= addr.vaddr[ldu_pkg::DCACHE_BANK_BIT];
			sec_req <= in_second;
			sec_bank <= next_vaddr[ldu_pkg::DCACHE_BANK_BIT];
		end else if (state == ldu_pkg::REQ_FIRST && done && cur_req.misaligned) begin
			// second half takes over and may switch bank
			cur_req <= sec_req;
			cur_bank <= sec_bank;
		end
	end

	// --------------------------------------
	// checks

	// one bank at a time, the one named by address bit 5 of the request on the bus
	one_bank_at_a_time: assert property (@(posedge CLK) disable iff (!nRST)
		!(REQ_bank0_valid && REQ_bank1_valid)
		&& (!busy || (REQ_bank1_valid == req.po_word[ldu_pkg::DCACHE_BANK_BIT-2])));

	// stalled request keeps its bank and its fields
	req_stable_while_waiting: assert property (@(posedge CLK) disable iff (!nRST)
		(busy && !done) |=> ($stable(req) && $stable(REQ_bank0_valid)
			&& $stable(REQ_bank1_valid)));

endmodule

// File: ldu_addr_pipeline.sv
// --------------------------------------
// ldu_addr_pipeline
// load address stage from operand gather
// through the address add to the data
// cache request
// --------------------------------------
`timescale 1ns/1ps

module ldu_addr_pipeline (
	input logic CLK,
	input logic nRST,

	// issue queue
	input ldu_pkg::ldu_issue_t issue,
	output logic issue_ready,

	// register file
	input logic A_reg_read_resp_valid,
	input ldu_pkg::word_t A_reg_read_resp_data,
	input ldu_pkg::word_t [ldu_pkg::PRF_BANK_COUNT-1:0] forward_data_by_bank,

	// data cache banks
	output logic REQ_bank0_valid,
	output logic REQ_bank1_valid,
	output ldu_pkg::ldu_req_t req,
	input logic REQ_bank0_early_ready,
	input logic REQ_bank1_early_ready
);

	// operand stage to address generation
	logic operand_valid;
	ldu_pkg::word_t operand_A;
	ldu_pkg::ldu_op_t operand_op;
	ldu_pkg::imm12_t operand_imm12;
	ldu_pkg::cq_index_t operand_cq_index;
	logic addr_ready;

	// address generation to request stage
	ldu_pkg::ldu_addr_t addr;
	logic accept;

	ldu_operand_stage u_operand_stage (
		.CLK(CLK),
		.nRST(nRST),
		.issue(issue),
		.issue_ready(issue_ready),
		.A_reg_read_resp_valid(A_reg_read_resp_valid),
		.A_reg_read_resp_data(A_reg_read_resp_data),
		.forward_data_by_bank(forward_data_by_bank),
		.operand_valid(operand_valid),
		.operand_A(operand_A),
		.operand_op(operand_op),
		.operand_imm12(operand_imm12),
		.operand_cq_index(operand_cq_index),
		.addr_ready(addr_ready)
	);

	ldu_addr_gen u_addr_gen (
		.CLK(CLK),
		.nRST(nRST),
		.operand_valid(operand_valid),
		.operand_A(operand_A),
		.operand_op(operand_op),
		.operand_imm12(operand_imm12),
		.operand_cq_index(operand_cq_index),
		.addr_ready(addr_ready),
		.addr(addr),
		.accept(accept)
	);

	ldu_req_stage u_req_stage (
		.CLK(CLK),
		.nRST(nRST),
		.addr(addr),
		.accept(accept),
		.REQ_bank0_valid(REQ_bank0_valid),
		.REQ_bank1_valid(REQ_bank1_valid),
		.req(req),
		.REQ_bank0_early_ready(REQ_bank0_early_ready),
		.REQ_bank1_early_ready(REQ_bank1_early_ready)
	);

endmodule

// File: tb_ldu_addr_pipeline.sv
// --------------------------------------
// tb_ldu_addr_pipeline
// golden-file testbench for the load
// address stage with random early ready
// on both cache banks
// --------------------------------------
`timescale 1ns/1ps

module tb_ldu_addr_pipeline;

	localparam int NUM_LOADS = 20;
	localparam int FIELDS = 20;
	localparam int MAX_WAIT = 200;

	// golden column offsets, each request record is bank mq mis vpn po mask
	localparam int F_OP = 0;
	localparam int F_IMM = 1;
	localparam int F_SRC = 2;
	localparam int F_A = 3;
	localparam int F_BANK = 4;
	localparam int F_CQ = 5;
	localparam int F_DLY = 6;
	localparam int F_NREQ = 7;
	localparam int F_REQ0 = 8;
	localparam int F_REQ1 = 14;

	logic CLK;
	logic nRST;
	ldu_pkg::ldu_issue_t issue;
	logic issue_ready;
	logic A_reg_read_resp_valid;
	ldu_pkg::word_t A_reg_read_resp_data;
	ldu_pkg::word_t [ldu_pkg::PRF_BANK_COUNT-1:0] forward_data_by_bank;
	logic REQ_bank0_valid;
	logic REQ_bank1_valid;
	ldu_pkg::ldu_req_t req;
	logic REQ_bank0_early_ready;
	logic REQ_bank1_early_ready;

	logic [31:0] golden [0:NUM_LOADS*FIELDS-1];
	ldu_pkg::ldu_req_t exp_req [0:2*NUM_LOADS-1];
	logic exp_bank [0:2*NUM_LOADS-1];
	int exp_count;
	int got_count;
	int checks;
	int errors;
	int stall_cycles;
	logic timed_out;
	integer seed;

	// monitor history for the hold check
	logic prev_waiting;
	ldu_pkg::ldu_req_t prev_req;
	logic [1:0] prev_valids;

	ldu_addr_pipeline dut_i (
		.CLK(CLK),
		.nRST(nRST),
		.issue(issue),
		.issue_ready(issue_ready),
		.A_reg_read_resp_valid(A_reg_read_resp_valid),
		.A_reg_read_resp_data(A_reg_read_resp_data),
		.forward_data_by_bank(forward_data_by_bank),
		.REQ_bank0_valid(REQ_bank0_valid),
		.REQ_bank1_valid(REQ_bank1_valid),
		.req(req),
		.REQ_bank0_early_ready(REQ_bank0_early_ready),
		.REQ_bank1_early_ready(REQ_bank1_early_ready)
	);

	always #50 CLK = ~CLK;

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	// flatten the golden records into the expected request stream
	task automatic build_expected();
		int base;
		int nreq;
		exp_count = 0;
		for (int i = 0; i < NUM_LOADS; i++) begin
			nreq = golden[i * FIELDS + F_NREQ];
			for (int r = 0; r < nreq; r++) begin
				base = i * FIELDS + ((r == 0) ? F_REQ0 : F_REQ1);
				exp_bank[exp_count] = golden[base][0];
				exp_req[exp_count].is_mq = golden[base + 1][0];
				exp_req[exp_count].misaligned = golden[base + 2][0];
				exp_req[exp_count].vpn = golden[base + 3][19:0];
				exp_req[exp_count].po_word = golden[base + 4][9:0];
				exp_req[exp_count].byte_mask = golden[base + 5][3:0];
				exp_req[exp_count].cq_index = golden[i * FIELDS + F_CQ][3:0];
				exp_count++;
			end
		end
	endtask

	// issue one load, then feed its operand A on the forward bus or as a response
	task automatic drive_load(input int i);
		int base;
		int src;
		int wait_cycles;
		base = i * FIELDS;
		src = golden[base + F_SRC];
		issue.valid = 1'b1;
		issue.op = golden[base + F_OP][3:0];
		issue.imm12 = golden[base + F_IMM][11:0];
		issue.A_forward = (src == 1);
		issue.A_is_zero = (src == 0);
		issue.A_bank = golden[base + F_BANK][1:0];
		issue.cq_index = golden[base + F_CQ][3:0];
		wait_cycles = 0;
		@(negedge CLK);
		while (!issue_ready && wait_cycles < MAX_WAIT) begin
			// only a stalled request stage backs up to the issue port
			check_value("REQ_bank0_valid | REQ_bank1_valid",
				REQ_bank0_valid | REQ_bank1_valid, 1);
			stall_cycles++;
			wait_cycles++;
			@(negedge CLK);
		end
		if (!issue_ready) begin
			$display("ERROR: load %0d was never accepted, issue_ready stayed low", i);
			errors++;
			timed_out = 1'b1;
		end else begin
			@(posedge CLK);
			#1;
			issue.valid = 1'b0;
			if (src == 1) begin
				for (int b = 0; b < ldu_pkg::PRF_BANK_COUNT; b++) begin
					if (b == issue.A_bank) begin
						forward_data_by_bank[b] = golden[base + F_A];
					end else begin
						forward_data_by_bank[b] = $random(seed);
					end
				end
			end else if (src == 2) begin
				repeat (golden[base + F_DLY] - 1) begin
					@(posedge CLK);
					#1;
				end
				A_reg_read_resp_valid = 1'b1;
				A_reg_read_resp_data = golden[base + F_A];
				@(posedge CLK);
				#1;
				A_reg_read_resp_valid = 1'b0;
			end
		end
	endtask

	task automatic wait_for_drain();
		int wait_cycles;
		wait_cycles = 0;
		while (got_count < exp_count && wait_cycles < MAX_WAIT) begin
			@(posedge CLK);
			wait_cycles++;
		end
		if (got_count < exp_count) begin
			$display("ERROR: timed out with %0d of %0d requests completed",
				got_count, exp_count);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	// --------------------------------------
	// early ready drawn fresh every cycle

	always @(posedge CLK) begin
		#1;
		REQ_bank0_early_ready = ($random(seed) & 3) != 0;
		REQ_bank1_early_ready = ($random(seed) & 3) != 0;
	end

	// --------------------------------------
	// request monitor sampled mid-cycle

	always @(negedge CLK) begin
		logic completes;
		if (nRST) begin
			check_value("REQ_bank0_valid & REQ_bank1_valid",
				REQ_bank0_valid & REQ_bank1_valid, 0);
			if (prev_waiting) begin
				check_value("req", req, prev_req);
				check_value("REQ_bank1_valid, REQ_bank0_valid",
					{REQ_bank1_valid, REQ_bank0_valid}, prev_valids);
			end
			completes = (REQ_bank0_valid & REQ_bank0_early_ready)
				| (REQ_bank1_valid & REQ_bank1_early_ready);
			prev_waiting = (REQ_bank0_valid | REQ_bank1_valid) & ~completes;
			prev_req = req;
			prev_valids = {REQ_bank1_valid, REQ_bank0_valid};
			if (completes) begin
				if (got_count >= exp_count) begin
					$display("ERROR: a request completed after the golden stream ended");
					errors++;
				end else begin
					check_value("REQ_bank1_valid", REQ_bank1_valid, exp_bank[got_count]);
					check_value("req.is_mq", req.is_mq, exp_req[got_count].is_mq);
					check_value("req.misaligned", req.misaligned,
						exp_req[got_count].misaligned);
					check_value("req.vpn", req.vpn, exp_req[got_count].vpn);
					check_value("req.po_word", req.po_word, exp_req[got_count].po_word);
					check_value("req.byte_mask", req.byte_mask,
						exp_req[got_count].byte_mask);
					check_value("req.cq_index", req.cq_index,
						exp_req[got_count].cq_index);
					got_count++;
				end
			end
		end
	end

	initial begin
		CLK = 1'b0;
		nRST = 1'b0;
		issue = '0;
		A_reg_read_resp_valid = 1'b0;
		A_reg_read_resp_data = '0;
		forward_data_by_bank = '0;
		REQ_bank0_early_ready = 1'b0;
		REQ_bank1_early_ready = 1'b0;
		seed = 32'h75d8;
		checks = 0;
		errors = 0;
		got_count = 0;
		stall_cycles = 0;
		timed_out = 1'b0;
		prev_waiting = 1'b0;
		prev_req = '0;
		prev_valids = 2'b00;
		$readmemh("ldu_golden.hex", golden);
		build_expected();
		repeat (4) @(posedge CLK);
		#1;
		nRST = 1'b1;
		// idle out of reset
		@(negedge CLK);
		check_value("issue_ready", issue_ready, 1);
		check_value("REQ_bank0_valid", REQ_bank0_valid, 0);
		check_value("REQ_bank1_valid", REQ_bank1_valid, 0);
		@(posedge CLK);
		#1;
		for (int i = 0; i < NUM_LOADS && !timed_out; i++) begin
			drive_load(i);
		end
		if (!timed_out) begin
			wait_for_drain();
		end
		if (!timed_out) begin
			// quiet tail catches duplicated requests
			repeat (20) @(posedge CLK);
			if (stall_cycles == 0) begin
				$display("ERROR: issue_ready never dropped under back-pressure");
				errors++;
			end
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: ldu_golden.hex
// op imm src a_value a_bank cq dly nreq, then req0 and req1 as: bank mq mis vpn po mask
// src 0 zero, 1 forward, 2 register read after dly cycles; unused req1 is all zeros
2 000 1 00001000 0 0 0 1  0 0 0 00001 000 f  0 0 0 00000 000 0
1 004 0 00000000 0 1 0 1  0 0 0 00000 001 3  0 0 0 00000 000 0
0 023 2 80000040 0 2 3 1  1 0 0 80000 018 8  0 0 0 00000 000 0
5 ffe 1 12345678 2 3 0 1  1 0 0 12345 19d c  0 0 0 00000 000 0
2 7ff 0 00000000 1 4 0 2  1 0 1 00000 1ff 8  0 1 0 00000 200 7
1 003 1 0000ffe0 3 5 0 2  1 0 1 0000f 3f8 8  1 1 0 0000f 3f9 1
2 001 2 00002ffc 0 6 1 2  1 0 1 00002 3ff e  0 1 0 00003 000 1
4 800 1 00010805 1 7 0 1  0 0 0 00010 001 2  0 0 0 00000 000 0
2 fe0 2 40000100 0 8 5 1  1 0 0 40000 038 f  0 0 0 00000 000 0
5 021 0 00000000 0 9 0 1  1 0 0 00000 008 6  0 0 0 00000 000 0
2 002 1 deadbe1c 2 a 0 2  0 0 1 deadb 387 c  1 1 0 deadb 388 3
0 03f 2 00000fc0 1 b 2 1  1 0 0 00000 3ff 8  0 0 0 00000 000 0
2 ffc 1 00000002 0 c 0 2  1 0 1 fffff 3ff c  0 1 0 00000 000 3
1 012 0 00000000 0 d 0 1  0 0 0 00000 004 c  0 0 0 00000 000 0
2 100 2 7fffff00 3 e 6 1  0 0 0 80000 000 f  0 0 0 00000 000 0
1 fff 1 00000044 1 f 0 2  0 0 1 00000 010 8  0 1 0 00000 011 1
0 5a5 1 0a0b0c00 2 0 0 1  1 0 0 0a0b1 069 2  0 0 0 00000 000 0
2 03d 2 00004000 2 1 4 2  1 0 1 00004 00f e  0 1 0 00004 010 1
0 f9b 0 00000000 0 2 0 1  0 0 0 fffff 3e6 8  0 0 0 00000 000 0
2 020 1 00000fe0 0 3 0 1  0 0 0 00001 000 f  0 0 0 00000 000 0

// File: filelist.f
ldu_pkg.sv
ldu_operand_stage.sv
ldu_addr_gen.sv
ldu_req_stage.sv
ldu_addr_pipeline.sv
tb_ldu_addr_pipeline.sv

// File: run_sim.sh
#!/bin/sh
# build and run the load address stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_ldu_addr_pipeline -o tb_ldu_addr_pipeline \
	&& ./obj_dir/tb_ldu_addr_pipeline > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "^RESULT: PASS$" sim.log && exit 0 || exit 1
